//--- verilog/csr_pkg.sv
/*
  CSR package
  operation codes, machine and loop addresses, counter region
  id register values, machine select codes, loop field codes
  access request, resolved write, address union, loop values
  set/clear/write helper shared by port and counters
*/
package csr_pkg;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  ////////////////////
  // addresses
  ////////////////////
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MCPUID    = 12'hF00;
  localparam logic [11:0] CSR_MIMPID    = 12'hF01;
  localparam logic [11:0] CSR_MHARTID   = 12'hF10;
  localparam logic [11:0] CSR_HWLP_BASE = 12'h7B0;
  localparam logic [11:0] CSR_PCER      = 12'h7A0;
  localparam logic [11:0] CSR_PCMR      = 12'h7A1;
  localparam logic [11:0] CSR_PCCR_ALL  = 12'h79F;
  // 0x780 to 0x79F, one counter per index
  localparam logic [6:0]  CSR_PCCR_GROUP = 7'b0111100;

  // RV32I, anonymous source
  localparam logic [31:0] MCPUID_VALUE = 32'h0000_0100;
  localparam logic [31:0] MIMPID_VALUE = 32'h0000_8000;

  localparam int N_HWLP = 2;

  // dense select for the machine block, addresses overlap in low bits
  localparam logic [3:0] MSEL_MSTATUS  = 4'd0;
  localparam logic [3:0] MSEL_MSCRATCH = 4'd1;
  localparam logic [3:0] MSEL_MEPC     = 4'd2;
  localparam logic [3:0] MSEL_MCAUSE   = 4'd3;
  localparam logic [3:0] MSEL_MCPUID   = 4'd4;
  localparam logic [3:0] MSEL_MIMPID   = 4'd5;
  localparam logic [3:0] MSEL_MHARTID  = 4'd6;
  localparam logic [3:0] MSEL_NONE     = 4'hF;

  // word within a loop, low two address bits
  localparam logic [1:0] HWLP_FIELD_START = 2'd0;
  localparam logic [1:0] HWLP_FIELD_END   = 2'd1;
  localparam logic [1:0] HWLP_FIELD_COUNT = 2'd2;

  ////////////////////
  // types
  ////////////////////
  typedef union packed {
    logic [11:0] flat;
    struct packed {
      logic [6:0] grp;
      logic [4:0] idx;
    } pccr;
  } csr_addr_u;

  typedef struct packed {
    logic        access;
    csr_op_e     op;
    csr_addr_u   addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic        we;
    logic [3:0]  reg_sel;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic [31:0] lp_start;
    logic [31:0] lp_end;
    logic [31:0] lp_count;
  } hwlp_vals_t;

  // new register value for one access
  function automatic logic [31:0] csr_apply_op(
    input csr_op_e     op,
    input logic [31:0] cur,
    input logic [31:0] wval
  );
    logic [31:0] res;
    case (op)
      CSR_OP_WRITE: res = wval;
      CSR_OP_SET:   res = cur | wval;
      CSR_OP_CLEAR: res = cur & ~wval;
      default:      res = cur;
    endcase
    return res;
  endfunction

endpackage

//--- verilog/perf_pkg.sv
/*
  performance counter package
  counter count, event bit positions
  raw event struct, counter register select
*/
package perf_pkg;

  localparam int N_PERF_COUNTERS = 10;

  // bit position of each event in the counter vector
  localparam int EV_CYCLE      = 0;
  localparam int EV_INSTR      = 1;
  localparam int EV_LD_STALL   = 2;
  localparam int EV_JR_STALL   = 3;
  localparam int EV_IMISS      = 4;
  localparam int EV_LOAD       = 5;
  localparam int EV_STORE      = 6;
  localparam int EV_JUMP       = 7;
  localparam int EV_BRANCH     = 8;
  localparam int EV_COMPRESSED = 9;

  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic jump;
    logic branch;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

  typedef enum logic [2:0] {
    PERF_SEL_NONE     = 3'd0,
    PERF_SEL_PCER     = 3'd1,
    PERF_SEL_PCMR     = 3'd2,
    PERF_SEL_PCCR_ONE = 3'd3,
    PERF_SEL_PCCR_ALL = 3'd4
  } perf_sel_e;

endpackage

//--- verilog/csr_port.sv
/*
  CSR access port
  region decode: machine, loops, performance counters
  read data multiplexer
  resolved write word for machine and loop registers
*/
module csr_port
  import csr_pkg::*, perf_pkg::*;
(
  input  csr_req_t    csr_req_i,
  input  logic [31:0] mach_rdata_i,
  input  logic [31:0] hwlp_rdata_i,
  input  logic [31:0] perf_rdata_i,
  output logic [31:0] csr_rdata_o,
  output csr_wr_t     mach_wr_o,
  output csr_wr_t     hwlp_wr_o,
  output perf_sel_e   perf_sel_o
);

  logic [11:0] addr;
  logic [3:0]  mach_sel;
  logic        is_mach;
  logic        is_hwlp;
  logic        we;
  logic [31:0] wdata;

  assign addr = csr_req_i.addr.flat;

  ////////////////////
  // decode
  ////////////////////
  always_comb
  begin
    mach_sel = MSEL_NONE;
    case (addr)
      CSR_MSTATUS:  mach_sel = MSEL_MSTATUS;
      CSR_MSCRATCH: mach_sel = MSEL_MSCRATCH;
      CSR_MEPC:     mach_sel = MSEL_MEPC;
      CSR_MCAUSE:   mach_sel = MSEL_MCAUSE;
      CSR_MCPUID:   mach_sel = MSEL_MCPUID;
      CSR_MIMPID:   mach_sel = MSEL_MIMPID;
      CSR_MHARTID:  mach_sel = MSEL_MHARTID;
      default:      ;
    endcase
  end

  assign is_mach = (mach_sel != MSEL_NONE);

  // three words per loop, fourth slot unmapped
  assign is_hwlp = (addr[11:4] == CSR_HWLP_BASE[11:4]) &&
                   (int'(addr[3:2]) < N_HWLP) &&
                   (addr[1:0] <= HWLP_FIELD_COUNT);

  // write-all sits inside the counter group, check it first
  always_comb
  begin
    perf_sel_o = PERF_SEL_NONE;
    if (addr == CSR_PCER)
      perf_sel_o = PERF_SEL_PCER;
    else if (addr == CSR_PCMR)
      perf_sel_o = PERF_SEL_PCMR;
    else if (addr == CSR_PCCR_ALL)
      perf_sel_o = PERF_SEL_PCCR_ALL;
    else if (addr[11:5] == CSR_PCCR_GROUP)
      perf_sel_o = PERF_SEL_PCCR_ONE;
  end

  ////////////////////
  // read and write
  ////////////////////
  always_comb
  begin
    csr_rdata_o = '0;
    if (is_mach)
      csr_rdata_o = mach_rdata_i;
    else if (is_hwlp)
      csr_rdata_o = hwlp_rdata_i;
    else if (perf_sel_o != PERF_SEL_NONE)
      csr_rdata_o = perf_rdata_i;
  end

  assign we    = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);
  // set and clear work on the word being read
  assign wdata = csr_apply_op(csr_req_i.op, csr_rdata_o, csr_req_i.wdata);

  // select stays valid without access, it also drives the reads
  assign mach_wr_o = '{we: we & is_mach, reg_sel: mach_sel, data: wdata};
  assign hwlp_wr_o = '{we: we & is_hwlp, reg_sel: addr[3:0], data: wdata};

endmodule

//--- verilog/machine_csrs.sv
/*
  machine registers
  mstatus enable bit, mscratch, mepc, mcause
  exception capture of PC and cause over CSR writes
  constant mcpuid, mimpid and mhartid reads
*/
module machine_csrs
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_t     wr_i,
  input  logic [3:0]  reg_sel_i,
  input  logic [4:0]  core_id_i,
  input  logic [4:0]  cluster_id_i,
  input  logic [31:0] curr_pc_i,
  input  logic        save_pc_i,
  input  logic [5:0]  exc_cause_i,
  input  logic        save_cause_i,
  output logic [31:0] rdata_o,
  output logic        irq_enable_o,
  output logic [31:0] epcr_o
);

  logic        irq_en_q;
  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;
  // bit 5 is the interrupt flag, read back in bit 31
  logic [5:0]  cause_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_en_q   <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      cause_q    <= '0;
    end
    else
    begin
      if (wr_i.we)
      begin
        case (wr_i.reg_sel)
          MSEL_MSTATUS:  irq_en_q   <= wr_i.data[0];
          MSEL_MSCRATCH: mscratch_q <= wr_i.data;
          MSEL_MEPC:     mepc_q     <= wr_i.data;
          MSEL_MCAUSE:   cause_q    <= {wr_i.data[31], wr_i.data[4:0]};
          // id registers are read-only
          default:       ;
        endcase
      end
      // exception capture last, so it wins
      if (save_pc_i)
        mepc_q <= curr_pc_i;
      if (save_cause_i)
        cause_q <= exc_cause_i;
    end
  end

  always_comb
  begin
    case (reg_sel_i)
      // machine mode only, bits 2:1 fixed
      MSEL_MSTATUS:  rdata_o = {29'b0, 2'b11, irq_en_q};
      MSEL_MSCRATCH: rdata_o = mscratch_q;
      MSEL_MEPC:     rdata_o = mepc_q;
      MSEL_MCAUSE:   rdata_o = {cause_q[5], 26'b0, cause_q[4:0]};
      MSEL_MCPUID:   rdata_o = MCPUID_VALUE;
      MSEL_MIMPID:   rdata_o = MIMPID_VALUE;
      MSEL_MHARTID:  rdata_o = {22'b0, cluster_id_i, core_id_i};
      default:       rdata_o = '0;
    endcase
  end

  assign irq_enable_o = irq_en_q;
  assign epcr_o       = mepc_q;

endmodule

//--- verilog/hwlp_regs.sv
/*
  hardware loop registers
  start, end and count per loop
  CSR writes, count decrement from the core, read mux
*/
module hwlp_regs
  import csr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  csr_wr_t                 wr_i,
  input  logic [3:0]              rd_sel_i,
  input  logic [N_HWLP-1:0]       cnt_dec_i,
  output logic [31:0]             rdata_o,
  output hwlp_vals_t [N_HWLP-1:0] hwlp_o
);

  hwlp_vals_t [N_HWLP-1:0] lp_q;
  hwlp_vals_t [N_HWLP-1:0] lp_d;

  // loop in bits 3:2, field in bits 1:0
  always_comb
  begin
    lp_d = lp_q;
    for (int i = 0; i < N_HWLP; i++)
    begin
      if (cnt_dec_i[i])
        lp_d[i].lp_count = lp_q[i].lp_count - 32'd1;
      // CSR write after the decrement, write wins
      if (wr_i.we && (int'(wr_i.reg_sel[3:2]) == i))
      begin
        case (wr_i.reg_sel[1:0])
          HWLP_FIELD_START: lp_d[i].lp_start = wr_i.data;
          HWLP_FIELD_END:   lp_d[i].lp_end   = wr_i.data;
          HWLP_FIELD_COUNT: lp_d[i].lp_count = wr_i.data;
          default:          ;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      lp_q <= '0;
    else
      lp_q <= lp_d;
  end

  always_comb
  begin
    rdata_o = '0;
    for (int i = 0; i < N_HWLP; i++)
    begin
      if (int'(rd_sel_i[3:2]) == i)
      begin
        case (rd_sel_i[1:0])
          HWLP_FIELD_START: rdata_o = lp_q[i].lp_start;
          HWLP_FIELD_END:   rdata_o = lp_q[i].lp_end;
          HWLP_FIELD_COUNT: rdata_o = lp_q[i].lp_count;
          default:          ;
        endcase
      end
    end
  end

  assign hwlp_o = lp_q;

endmodule

//--- verilog/perf_counters.sv
/*
  performance counters
  event qualification and registered increment
  PCER event enable, PCMR global enable and saturation
  counter update, single and write-all CSR access
*/
module perf_counters
  import csr_pkg::*, perf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  csr_req_t     csr_req_i,
  input  perf_sel_e    perf_sel_i,
  input  perf_events_t events_i,
  output logic [31:0]  rdata_o
);

  logic                             id_valid_q;
  logic [N_PERF_COUNTERS-1:0]       ev_in;
  logic [N_PERF_COUNTERS-1:0]       inc;
  logic [N_PERF_COUNTERS-1:0]       inc_q;
  logic [N_PERF_COUNTERS-1:0]       pcer_q;
  logic [1:0]                       pcmr_q;
  logic [N_PERF_COUNTERS-1:0][31:0] cnt_q;
  logic [N_PERF_COUNTERS-1:0][31:0] cnt_d;
  logic [31:0]                      pcer_word;
  logic [31:0]                      pcmr_word;
  logic [31:0]                      pcer_new;
  logic [31:0]                      pcmr_new;
  logic [4:0]                       idx;
  logic                             we;

  ////////////////////
  // events
  ////////////////////
  // stalls, jumps and branches belong to the instruction that left ID
  assign ev_in[EV_CYCLE]      = 1'b1;
  assign ev_in[EV_INSTR]      = events_i.id_valid & events_i.is_decoding;
  assign ev_in[EV_LD_STALL]   = events_i.ld_stall & id_valid_q;
  assign ev_in[EV_JR_STALL]   = events_i.jr_stall & id_valid_q;
  assign ev_in[EV_IMISS]      = events_i.imiss;
  assign ev_in[EV_LOAD]       = events_i.mem_load;
  assign ev_in[EV_STORE]      = events_i.mem_store;
  assign ev_in[EV_JUMP]       = events_i.jump & id_valid_q;
  assign ev_in[EV_BRANCH]     = events_i.branch & id_valid_q;
  assign ev_in[EV_COMPRESSED] = events_i.id_valid & events_i.is_decoding &
                                events_i.is_compressed;

  // PCMR bit 0 is the global enable
  assign inc = ev_in & pcer_q & {N_PERF_COUNTERS{pcmr_q[0]}};

  ////////////////////
  // CSR side
  ////////////////////
  assign we        = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);
  assign idx       = csr_req_i.addr.pccr.idx;
  assign pcer_word = {{(32 - N_PERF_COUNTERS){1'b0}}, pcer_q};
  assign pcmr_word = {30'b0, pcmr_q};
  assign pcer_new  = csr_apply_op(csr_req_i.op, pcer_word, csr_req_i.wdata);
  assign pcmr_new  = csr_apply_op(csr_req_i.op, pcmr_word, csr_req_i.wdata);

  always_comb
  begin
    for (int i = 0; i < N_PERF_COUNTERS; i++)
    begin
      cnt_d[i] = cnt_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1]))
        cnt_d[i] = cnt_q[i] + 32'd1;
      // CSR access overrides a pending increment
      if (we && ((perf_sel_i == PERF_SEL_PCCR_ALL) ||
                 ((perf_sel_i == PERF_SEL_PCCR_ONE) && (int'(idx) == i))))
        cnt_d[i] = csr_apply_op(csr_req_i.op, cnt_q[i], csr_req_i.wdata);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= 2'b11;
      cnt_q      <= '0;
    end
    else
    begin
      id_valid_q <= events_i.id_valid;
      inc_q      <= inc;
      cnt_q      <= cnt_d;
      if (we && (perf_sel_i == PERF_SEL_PCER))
        pcer_q <= pcer_new[N_PERF_COUNTERS-1:0];
      if (we && (perf_sel_i == PERF_SEL_PCMR))
        pcmr_q <= pcmr_new[1:0];
    end
  end

  // write-all and unused indices read zero
  always_comb
  begin
    rdata_o = '0;
    case (perf_sel_i)
      PERF_SEL_PCER:     rdata_o = pcer_word;
      PERF_SEL_PCMR:     rdata_o = pcmr_word;
      PERF_SEL_PCCR_ONE:
      begin
        if (int'(idx) < N_PERF_COUNTERS)
          rdata_o = cnt_q[idx];
      end
      default:           ;
    endcase
  end

endmodule

//--- verilog/csr_subsystem.sv
/*
  CSR subsystem top level
  access port, machine registers, loop registers
  and performance counters on one CSR port
*/
module csr_subsystem
  import csr_pkg::*, perf_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  csr_req_t                csr_req_i,
  output logic [31:0]             csr_rdata_o,
  input  logic [4:0]              core_id_i,
  input  logic [4:0]              cluster_id_i,
  input  logic [31:0]             curr_pc_i,
  input  logic                    save_pc_i,
  input  logic [5:0]              exc_cause_i,
  input  logic                    save_cause_i,
  output logic                    irq_enable_o,
  output logic [31:0]             epcr_o,
  input  logic [N_HWLP-1:0]       cnt_dec_i,
  output hwlp_vals_t [N_HWLP-1:0] hwlp_o,
  input  perf_events_t            events_i
);

  logic [31:0] mach_rdata;
  logic [31:0] hwlp_rdata;
  logic [31:0] perf_rdata;
  csr_wr_t     mach_wr;
  csr_wr_t     hwlp_wr;
  perf_sel_e   perf_sel;

  csr_port u_csr_port (
    .csr_req_i    (csr_req_i),
    .mach_rdata_i (mach_rdata),
    .hwlp_rdata_i (hwlp_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .mach_wr_o    (mach_wr),
    .hwlp_wr_o    (hwlp_wr),
    .perf_sel_o   (perf_sel)
  );

  // write select doubles as read select
  machine_csrs u_machine_csrs (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (mach_wr),
    .reg_sel_i    (mach_wr.reg_sel),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .curr_pc_i    (curr_pc_i),
    .save_pc_i    (save_pc_i),
    .exc_cause_i  (exc_cause_i),
    .save_cause_i (save_cause_i),
    .rdata_o      (mach_rdata),
    .irq_enable_o (irq_enable_o),
    .epcr_o       (epcr_o)
  );

  hwlp_regs u_hwlp_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (hwlp_wr),
    .rd_sel_i  (hwlp_wr.reg_sel),
    .cnt_dec_i (cnt_dec_i),
    .rdata_o   (hwlp_rdata),
    .hwlp_o    (hwlp_o)
  );

  perf_counters u_perf_counters (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_req_i  (csr_req_i),
    .perf_sel_i (perf_sel),
    .events_i   (events_i),
    .rdata_o    (perf_rdata)
  );

endmodule

//--- bench/clk_gen.sv
/*
  clock and reset source
  8 ns clock, active-low reset held for 4 cycles
*/
module clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 4;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/tb_csr_subsystem.sv
/*
  testbench for the CSR subsystem
  trace reader, one line per cycle
  drive on the falling edge, check before the rising edge
  loop register port compared with the loop reads
  cycle limit and closing report
*/
module tb_csr_subsystem
  import csr_pkg::*, perf_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // 1 ns before the next rising edge
  localparam int SAMPLE_DELAY = 3;
  localparam int LIMIT_MARGIN = 20;

  typedef struct packed {
    logic              access;
    logic [1:0]        op;
    logic [11:0]       addr;
    logic [31:0]       wdata;
    logic              save_pc;
    logic [31:0]       pc;
    logic              save_cause;
    logic [5:0]        cause;
    logic [N_HWLP-1:0] cnt_dec;
    logic [9:0]        events;
    logic [4:0]        core_id;
    logic [4:0]        cluster_id;
    logic [31:0]       exp_rdata;
    logic              exp_irq;
    logic [31:0]       exp_epcr;
    // rdata, irq, epcr
    logic [2:0]        mask;
  } trace_line_t;

  logic                    clk;
  logic                    rst_n;
  csr_req_t                csr_req;
  logic [31:0]             csr_rdata;
  logic [4:0]              core_id;
  logic [4:0]              cluster_id;
  logic [31:0]             curr_pc;
  logic                    save_pc;
  logic [5:0]              exc_cause;
  logic                    save_cause;
  logic                    irq_enable;
  logic [31:0]             epcr;
  logic [N_HWLP-1:0]       cnt_dec;
  hwlp_vals_t [N_HWLP-1:0] hwlp;
  perf_events_t            events;

  trace_line_t trace_q[$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  csr_subsystem u_csr_subsystem (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req),
    .csr_rdata_o  (csr_rdata),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .curr_pc_i    (curr_pc),
    .save_pc_i    (save_pc),
    .exc_cause_i  (exc_cause),
    .save_cause_i (save_cause),
    .irq_enable_o (irq_enable),
    .epcr_o       (epcr),
    .cnt_dec_i    (cnt_dec),
    .hwlp_o       (hwlp),
    .events_i     (events)
  );

  ////////////////////
  // trace file
  ////////////////////
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v [16];
    trace_line_t t;
    fd = $fopen("bench/csr_trace.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("cannot open the trace file bench/csr_trace.txt");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      // comments and blank lines
      if (line.len() < 2 || line[0] == "#")
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                  v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
      if (n != 16)
      begin
        errors++;
        $display("trace line has %0d fields instead of 16: %s", n, line);
        continue;
      end
      t.access     = v[0][0];
      t.op         = v[1][1:0];
      t.addr       = v[2][11:0];
      t.wdata      = v[3];
      t.save_pc    = v[4][0];
      t.pc         = v[5];
      t.save_cause = v[6][0];
      t.cause      = v[7][5:0];
      t.cnt_dec    = v[8][N_HWLP-1:0];
      t.events     = v[9][9:0];
      t.core_id    = v[10][4:0];
      t.cluster_id = v[11][4:0];
      t.exp_rdata  = v[12];
      t.exp_irq    = v[13][0];
      t.exp_epcr   = v[14];
      t.mask       = v[15][2:0];
      trace_q.push_back(t);
    end
    $fclose(fd);
  endtask

  ////////////////////
  // drive and check
  ////////////////////
  task automatic drive_line(input trace_line_t t);
    csr_req.access    = t.access;
    csr_req.op        = csr_op_e'(t.op);
    csr_req.addr.flat = t.addr;
    csr_req.wdata     = t.wdata;
    save_pc           = t.save_pc;
    curr_pc           = t.pc;
    save_cause        = t.save_cause;
    exc_cause         = t.cause;
    cnt_dec           = t.cnt_dec;
    events            = t.events;
    core_id           = t.core_id;
    cluster_id        = t.cluster_id;
  endtask

  task automatic check_outputs(input trace_line_t t, input int step);
    if (t.mask[2])
    begin
      checks++;
      assert (csr_rdata === t.exp_rdata)
      else
      begin
        errors++;
        $display("** Error: csr_rdata_o step %0d addr %h expected %h actual %h",
                 step, t.addr, t.exp_rdata, csr_rdata);
      end
    end
    if (t.mask[1])
    begin
      checks++;
      assert (irq_enable === t.exp_irq)
      else
      begin
        errors++;
        $display("** Error: irq_enable_o step %0d expected %h actual %h",
                 step, t.exp_irq, irq_enable);
      end
    end
    if (t.mask[0])
    begin
      checks++;
      assert (epcr === t.exp_epcr)
      else
      begin
        errors++;
        $display("** Error: epcr_o step %0d expected %h actual %h",
                 step, t.exp_epcr, epcr);
      end
    end
  endtask

  // three words per loop from the base, start, end, count
  task automatic compare_loop_port(input trace_line_t t, input int step);
    int          lp;
    int          field;
    logic [31:0] port_val;
    lp    = (int'(t.addr) - int'(CSR_HWLP_BASE)) / 4;
    field = (int'(t.addr) - int'(CSR_HWLP_BASE)) % 4;
    if (!t.mask[2] || t.addr < CSR_HWLP_BASE || lp >= N_HWLP || field > 2)
      return;
    case (field)
      0:       port_val = hwlp[lp].lp_start;
      1:       port_val = hwlp[lp].lp_end;
      default: port_val = hwlp[lp].lp_count;
    endcase
    checks++;
    assert (port_val === t.exp_rdata)
    else
    begin
      errors++;
      $display("** Error: hwlp_o step %0d loop %0d field %0d expected %h actual %h",
               step, lp, field, t.exp_rdata, port_val);
    end
  endtask

  task automatic print_counts();
    $display("checks: %0d, errors: %0d", checks, errors);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin
    csr_req    = '0;
    save_pc    = 1'b0;
    curr_pc    = '0;
    save_cause = 1'b0;
    exc_cause  = '0;
    cnt_dec    = '0;
    events     = '0;
    core_id    = '0;
    cluster_id = '0;
    load_trace();
    if (trace_q.size() == 0)
    begin
      errors++;
      $display("the trace holds no cycles to run");
    end
    // one cycle per line plus margin for reset and drain
    cycle_limit = trace_q.size() + LIMIT_MARGIN;
    wait (rst_n === 1'b1);
    foreach (trace_q[i])
    begin
      @(negedge clk);
      drive_line(trace_q[i]);
      #SAMPLE_DELAY;
      check_outputs(trace_q[i], i);
      compare_loop_port(trace_q[i], i);
    end
    @(negedge clk);
    print_counts();
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // cycle counter that ends a hung run
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

//--- compile.f
verilog/csr_pkg.sv
verilog/perf_pkg.sv
verilog/csr_port.sv
verilog/machine_csrs.sv
verilog/hwlp_regs.sv
verilog/perf_counters.sv
verilog/csr_subsystem.sv
bench/clk_gen.sv
bench/tb_csr_subsystem.sv

//--- Makefile
# Verilator build for the CSR subsystem

TOP := tb_csr_subsystem
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f compile.f --top-module csr_subsystem

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/csr_trace.txt
# one cycle per line, all hex: access op addr wdata save_pc pc save_cause cause cnt_dec
# events core_id cluster_id exp_rdata exp_irq exp_epcr mask(4 rdata, 2 irq, 1 epcr)
# reset values and id registers
1 0 300 00000000 0 00000000 0 00 0 000 03 01 00000006 0 00000000 7
1 0 340 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 341 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 342 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 F00 00000000 0 00000000 0 00 0 000 03 01 00000100 0 00000000 7
1 0 F01 00000000 0 00000000 0 00 0 000 03 01 00008000 0 00000000 7
1 0 F10 00000000 0 00000000 0 00 0 000 03 01 00000023 0 00000000 7
1 0 F10 00000000 0 00000000 0 00 0 000 1F 02 0000005F 0 00000000 7
1 0 7A0 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 7A1 00000000 0 00000000 0 00 0 000 03 01 00000003 0 00000000 7
1 0 7B0 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 7B6 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 789 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 79F 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 0 123 00000000 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
# mscratch write, set, clear, none
1 1 340 A5A5F00F 0 00000000 0 00 0 000 03 01 00000000 0 00000000 7
1 2 340 0000FF00 0 00000000 0 00 0 000 03 01 A5A5F00F 0 00000000 7
1 3 340 A0000000 0 00000000 0 00 0 000 03 01 A5A5FF0F 0 00000000 7
1 0 340 FFFFFFFF 0 00000000 0 00 0 000 03 01 05A5FF0F 0 00000000 7
0 1 340 FFFFFFFF 0 00000000 0 00 0 000 03 01 00000000 0 00000000 3
1 0 340 00000000 0 00000000 0 00 0 000 03 01 05A5FF0F 0 00000000 7
# mstatus enable bit
1 1 300 00000001 0 00000000 0 00 0 000 03 01 00000006 0 00000000 7
1 0 300 00000000 0 00000000 0 00 0 000 03 01 00000007 1 00000000 7
1 3 300 00000001 0 00000000 0 00 0 000 03 01 00000007 1 00000000 7
1 0 300 00000000 0 00000000 0 00 0 000 03 01 00000006 0 00000000 7
1 2 300 00000001 0 00000000 0 00 0 000 03 01 00000006 0 00000000 7
1 0 300 00000000 0 00000000 0 00 0 000 03 01 00000007 1 00000000 7
# exception capture, saved values win over CSR writes
1 0 341 00000000 1 00001234 1 2B 0 000 03 01 00000000 1 00000000 7
1 0 341 00000000 0 00000000 0 00 0 000 03 01 00001234 1 00001234 7
1 0 342 00000000 0 00000000 0 00 0 000 03 01 8000000B 1 00001234 7
1 1 341 DEADBEEF 1 00002000 0 00 0 000 03 01 00001234 1 00001234 7
1 0 341 00000000 0 00000000 0 00 0 000 03 01 00002000 1 00002000 7
1 1 342 80000015 0 00000000 1 07 0 000 03 01 8000000B 1 00002000 7
1 0 342 00000000 0 00000000 0 00 0 000 03 01 00000007 1 00002000 7
1 1 342 80000015 0 00000000 0 00 0 000 03 01 00000007 1 00002000 7
1 0 342 00000000 0 00000000 0 00 0 000 03 01 80000015 1 00002000 7
1 1 341 00000100 0 00000000 0 00 0 000 03 01 00002000 1 00002000 7
1 0 341 00000000 0 00000000 0 00 0 000 03 01 00000100 1 00000100 7
# hardware loops
1 1 7B0 00000400 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 7B1 00000480 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 7B2 00000010 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 7B4 00000800 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 7B5 00000840 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 7B6 00000003 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 0 7B0 00000000 0 00000000 0 00 0 000 03 01 00000400 1 00000100 7
1 0 7B1 00000000 0 00000000 0 00 0 000 03 01 00000480 1 00000100 7
1 0 7B4 00000000 0 00000000 0 00 0 000 03 01 00000800 1 00000100 7
1 0 7B5 00000000 0 00000000 0 00 0 000 03 01 00000840 1 00000100 7
1 0 7B2 00000000 0 00000000 0 00 1 000 03 01 00000010 1 00000100 7
1 0 7B2 00000000 0 00000000 0 00 3 000 03 01 0000000F 1 00000100 7
1 0 7B6 00000000 0 00000000 0 00 0 000 03 01 00000002 1 00000100 7
1 1 7B6 00000009 0 00000000 0 00 2 000 03 01 00000002 1 00000100 7
1 0 7B6 00000000 0 00000000 0 00 0 000 03 01 00000009 1 00000100 7
1 0 7B2 00000000 0 00000000 0 00 0 000 03 01 0000000E 1 00000100 7
1 0 7B3 00000000 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
# counters: enable cycle and load, clear all, count
1 1 7A0 00000021 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 1 79F 00000000 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000001 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000002 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 002 03 01 00000000 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 002 03 01 00000001 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 002 03 01 00000001 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 000 03 01 00000002 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 000 03 01 00000003 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 000 03 01 00000003 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 0000000A 1 00000100 7
# global enable off, one increment still in flight
1 3 7A1 00000001 0 00000000 0 00 0 000 03 01 00000003 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 002 03 01 0000000C 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 0000000D 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 0000000D 1 00000100 7
1 0 785 00000000 0 00000000 0 00 0 000 03 01 00000003 1 00000100 7
# saturation, then wrap
1 1 7A1 00000003 0 00000000 0 00 0 000 03 01 00000002 1 00000100 7
1 1 780 FFFFFFFF 0 00000000 0 00 0 000 03 01 0000000D 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 FFFFFFFF 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 FFFFFFFF 1 00000100 7
1 3 7A1 00000002 0 00000000 0 00 0 000 03 01 00000003 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 FFFFFFFF 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000000 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000001 1 00000100 7
1 0 780 00000000 0 00000000 0 00 0 000 03 01 00000002 1 00000100 7
1 0 7A0 00000000 0 00000000 0 00 0 000 03 01 00000021 1 00000100 7
1 0 7A1 00000000 0 00000000 0 00 0 000 03 01 00000001 1 00000100 7
